// ==== hw/endpoint_settings.svh ====
`ifndef ENDPOINT_SETTINGS_SVH
`define ENDPOINT_SETTINGS_SVH

// Sizes
`define ENDPOINT_NUM_MSGS        4
`define ENDPOINT_CACHE_WORDS     128
`define ENDPOINT_FIFO_DEPTH      4

// Bus byte addresses
`define ENDPOINT_DESC_BASE       16'h0000
`define ENDPOINT_TX_SEND_ADDR    16'h1004
`define ENDPOINT_TX_CACHE_BASE   16'h2000
`define ENDPOINT_RX_CACHE_BASE   16'h3000
`define ENDPOINT_FIFO_POP_ADDR   16'h3400
`define ENDPOINT_STATUS_ADDR     16'h3404

// Header word, low bit of each field
`define ENDPOINT_HDR_DEST_LSB    28
`define ENDPOINT_HDR_SRC_LSB     24
`define ENDPOINT_HDR_MSG_LSB     20
`define ENDPOINT_HDR_LEN_LSB     0

`define ENDPOINT_DESC_START_LSB  0
`define ENDPOINT_DESC_LEN_LSB    8

`endif

// ==== hw/endpoint_pkg.sv ====
`include "endpoint_settings.svh"

package endpoint_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] bus_addr_t;
    typedef logic [$clog2(`ENDPOINT_CACHE_WORDS)-1:0] word_idx_t;
    typedef logic [3:0] node_id_t;
    typedef logic [$clog2(`ENDPOINT_NUM_MSGS)-1:0] msg_id_t;
    typedef logic [3:0] pkt_len_t;   // Payload words, 0 to 15

    // Source [18:15], message id [14:13], start word [12:4], length [3:0]
    typedef logic [18:0] req_entry_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_HEADER,
        RX_STORE,
        RX_DROP,
        RX_POST
    } rx_state_t;

endpackage

// ==== hw/word_cache.sv ====
`timescale 1ns/100ps

`include "endpoint_settings.svh"

module word_cache (
    input  logic                    clk,
    input  logic                    n_rst,
    input  logic                    wen,
    input  endpoint_pkg::word_idx_t waddr,
    input  endpoint_pkg::word_t     wdata,
    input  endpoint_pkg::word_idx_t raddr,
    output endpoint_pkg::word_t     rdata
);

    endpoint_pkg::word_t mem [`ENDPOINT_CACHE_WORDS];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `ENDPOINT_CACHE_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port is asynchronous so the bus sees data in the request cycle
    assign rdata = mem[raddr];

endmodule

// ==== hw/word_counter.sv ====
`timescale 1ns/100ps

module word_counter (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   load,
    input  endpoint_pkg::pkt_len_t load_len,
    input  logic                   step,
    output endpoint_pkg::pkt_len_t remaining,
    output logic                   last
);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= load_len;
        end else if (step && remaining != '0) begin
            remaining <= remaining - endpoint_pkg::pkt_len_t'(1);
        end
    end

    assign last = (remaining == endpoint_pkg::pkt_len_t'(1));   // Final word of the packet

endmodule

// ==== hw/tx_fsm.sv ====
`timescale 1ns/100ps

`include "endpoint_settings.svh"

module tx_fsm (
    input  logic                    clk,
    input  logic                    n_rst,
    input  logic                    send,
    input  endpoint_pkg::msg_id_t   send_msg,
    input  endpoint_pkg::word_idx_t start_word,
    input  endpoint_pkg::pkt_len_t  send_len,
    input  endpoint_pkg::node_id_t  node_id,
    output endpoint_pkg::word_idx_t cache_raddr,
    input  endpoint_pkg::word_t     cache_rdata,
    output logic                    cache_owned,
    output logic                    out_valid,
    output endpoint_pkg::word_t     out_data,
    output logic                    tx_busy
);

    endpoint_pkg::tx_state_t state, next_state;
    endpoint_pkg::msg_id_t   msg_q;
    endpoint_pkg::word_idx_t rd_ptr;
    endpoint_pkg::pkt_len_t  remaining;
    endpoint_pkg::node_id_t  dest;
    endpoint_pkg::word_t     header;
    logic start, last;

    assign start = send && (state == endpoint_pkg::TX_IDLE);

    word_counter len_count (
        .clk(clk),
        .n_rst(n_rst),
        .load(start),
        .load_len(send_len),
        .step(state == endpoint_pkg::TX_PAYLOAD),
        .remaining(remaining),
        .last(last)
    );

    always_comb begin
        next_state = state;
        case (state)
            endpoint_pkg::TX_IDLE:    if (start) next_state = endpoint_pkg::TX_HEADER;
            endpoint_pkg::TX_HEADER:  next_state = (remaining == '0) ? endpoint_pkg::TX_IDLE
                                                                     : endpoint_pkg::TX_PAYLOAD;
            endpoint_pkg::TX_PAYLOAD: if (last) next_state = endpoint_pkg::TX_IDLE;
            default:                  next_state = endpoint_pkg::TX_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= endpoint_pkg::TX_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            msg_q  <= send_msg;
            rd_ptr <= start_word;
        end else if (state == endpoint_pkg::TX_PAYLOAD) begin
            rd_ptr <= rd_ptr + 1'b1;   // Wraps at the cache end
        end
    end

    // Destination is the message id plus one
    assign dest = endpoint_pkg::node_id_t'(msg_q) + endpoint_pkg::node_id_t'(1);

    always_comb begin
        header = '0;
        header[`ENDPOINT_HDR_DEST_LSB +: $bits(endpoint_pkg::node_id_t)] = dest;
        header[`ENDPOINT_HDR_SRC_LSB +: $bits(endpoint_pkg::node_id_t)]  = node_id;
        header[`ENDPOINT_HDR_MSG_LSB +: $bits(endpoint_pkg::msg_id_t)]   = msg_q;
        header[`ENDPOINT_HDR_LEN_LSB +: $bits(endpoint_pkg::pkt_len_t)]  = remaining;
    end

    assign cache_raddr = rd_ptr;
    assign cache_owned = (state == endpoint_pkg::TX_PAYLOAD);
    assign out_valid   = (state != endpoint_pkg::TX_IDLE);
    assign tx_busy     = (state != endpoint_pkg::TX_IDLE);
    assign out_data    = (state == endpoint_pkg::TX_HEADER) ? header :
                         cache_owned ? cache_rdata : '0;

endmodule

// ==== hw/rx_fsm.sv ====
`timescale 1ns/100ps

`include "endpoint_settings.svh"

module rx_fsm (
    input  logic                     clk,
    input  logic                     n_rst,
    input  endpoint_pkg::node_id_t   node_id,
    input  logic                     in_valid,
    input  endpoint_pkg::word_t      in_data,
    output logic                     cache_wen,
    output endpoint_pkg::word_idx_t  cache_waddr,
    output endpoint_pkg::word_t      cache_wdata,
    output logic                     post,
    output endpoint_pkg::req_entry_t entry
);

    endpoint_pkg::rx_state_t state, next_state;
    endpoint_pkg::word_idx_t wr_ptr, start_q;
    endpoint_pkg::node_id_t  src_q, hdr_dest;
    endpoint_pkg::msg_id_t   msg_q;
    endpoint_pkg::pkt_len_t  len_q, hdr_len;
    logic hdr_accept, for_me, step, last;

    assign hdr_dest = in_data[`ENDPOINT_HDR_DEST_LSB +: $bits(endpoint_pkg::node_id_t)];
    assign hdr_len  = in_data[`ENDPOINT_HDR_LEN_LSB +: $bits(endpoint_pkg::pkt_len_t)];
    assign for_me   = (hdr_dest == node_id);

    // A header may also land in the post cycle
    assign hdr_accept = in_valid && (state == endpoint_pkg::RX_HEADER ||
                                     state == endpoint_pkg::RX_POST);
    assign step = in_valid && (state == endpoint_pkg::RX_STORE ||
                               state == endpoint_pkg::RX_DROP);

    word_counter len_count (
        .clk(clk),
        .n_rst(n_rst),
        .load(hdr_accept),
        .load_len(hdr_len),
        .step(step),
        .remaining(),
        .last(last)
    );

    always_comb begin
        next_state = state;
        case (state)
            endpoint_pkg::RX_HEADER, endpoint_pkg::RX_POST: begin
                next_state = endpoint_pkg::RX_HEADER;
                if (hdr_accept && for_me) begin
                    next_state = (hdr_len == '0) ? endpoint_pkg::RX_POST : endpoint_pkg::RX_STORE;
                end else if (hdr_accept && hdr_len != '0) begin
                    next_state = endpoint_pkg::RX_DROP;   // Someone else's payload
                end
            end
            endpoint_pkg::RX_STORE: if (step && last) next_state = endpoint_pkg::RX_POST;
            endpoint_pkg::RX_DROP:  if (step && last) next_state = endpoint_pkg::RX_HEADER;
            default:                next_state = endpoint_pkg::RX_HEADER;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state  <= endpoint_pkg::RX_HEADER;
            wr_ptr <= '0;
        end else begin
            state <= next_state;
            if (cache_wen) wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Header fields kept for the FIFO entry
    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            src_q   <= in_data[`ENDPOINT_HDR_SRC_LSB +: $bits(endpoint_pkg::node_id_t)];
            msg_q   <= in_data[`ENDPOINT_HDR_MSG_LSB +: $bits(endpoint_pkg::msg_id_t)];
            len_q   <= hdr_len;
            start_q <= wr_ptr;
        end
    end

    assign cache_wen   = in_valid && (state == endpoint_pkg::RX_STORE);
    assign cache_waddr = wr_ptr;
    assign cache_wdata = in_data;
    assign post        = (state == endpoint_pkg::RX_POST);
    assign entry       = {src_q, msg_q, 2'b00, start_q, len_q};

endmodule

// ==== hw/req_fifo.sv ====
`timescale 1ns/100ps

`include "endpoint_settings.svh"

module req_fifo #(
    parameter int DEPTH = `ENDPOINT_FIFO_DEPTH
) (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     push,
    input  endpoint_pkg::req_entry_t push_entry,
    input  logic                     pop,
    output endpoint_pkg::req_entry_t head,
    output logic [3:0]               count,
    output logic                     overflow,
    input  logic                     clear_overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    endpoint_pkg::req_entry_t mem [DEPTH];
    logic [PTR_W-1:0] head_ptr, tail_ptr;
    logic full, empty, do_push, do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == 4'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;   // Entries posted into a full FIFO are lost
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) tail_ptr <= next_ptr(tail_ptr);
            if (do_pop) head_ptr <= next_ptr(head_ptr);
            count <= count + 4'(do_push) - 4'(do_pop);
            if (push && full) begin
                overflow <= 1'b1;
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[tail_ptr] <= push_entry;
    end

    assign head = mem[head_ptr];

endmodule

// ==== hw/endpoint.sv ====
`timescale 1ns/100ps

`include "endpoint_settings.svh"

module endpoint (
    input  logic                    clk,
    input  logic                    n_rst,
    input  endpoint_pkg::node_id_t  node_id,
    input  logic                    ren,
    input  logic                    wen,
    input  endpoint_pkg::bus_addr_t addr,
    input  endpoint_pkg::word_t     wdata,
    output endpoint_pkg::word_t     rdata,
    output logic                    error,
    output logic                    request_stall,
    input  logic                    in_valid,
    input  endpoint_pkg::word_t     in_data,
    output logic                    out_valid,
    output endpoint_pkg::word_t     out_data,
    output logic                    tx_busy
);

    localparam int DESC_BYTES  = `ENDPOINT_NUM_MSGS * 4;
    localparam int CACHE_BYTES = `ENDPOINT_CACHE_WORDS * 4;

    endpoint_pkg::word_idx_t  desc_start [`ENDPOINT_NUM_MSGS];
    endpoint_pkg::pkt_len_t   desc_len [`ENDPOINT_NUM_MSGS];
    endpoint_pkg::bus_addr_t  desc_off, tx_off, rx_off;
    endpoint_pkg::msg_id_t    desc_sel, send_msg;
    endpoint_pkg::word_idx_t  tx_idx, rx_idx, tx_fsm_raddr, tx_cache_raddr;
    endpoint_pkg::word_idx_t  rx_waddr;
    endpoint_pkg::word_t      desc_word, tx_cache_rdata, rx_cache_rdata, rx_wdata;
    endpoint_pkg::req_entry_t post_entry, fifo_head;
    logic [3:0] fifo_count;
    logic desc_hit, send_hit, tx_hit, rx_hit, pop_hit, status_hit;
    logic desc_wen, send, tx_bus_wen, tx_owned, rx_wen, post;
    logic fifo_pop, clear_overflow, overflow;

    // Address decode, offsets relative to each region
    assign desc_off   = addr - `ENDPOINT_DESC_BASE;
    assign tx_off     = addr - `ENDPOINT_TX_CACHE_BASE;
    assign rx_off     = addr - `ENDPOINT_RX_CACHE_BASE;
    assign desc_hit   = desc_off < endpoint_pkg::bus_addr_t'(DESC_BYTES);
    assign tx_hit     = tx_off < endpoint_pkg::bus_addr_t'(CACHE_BYTES);
    assign rx_hit     = rx_off < endpoint_pkg::bus_addr_t'(CACHE_BYTES);
    assign send_hit   = (addr == `ENDPOINT_TX_SEND_ADDR);
    assign pop_hit    = (addr == `ENDPOINT_FIFO_POP_ADDR);
    assign status_hit = (addr == `ENDPOINT_STATUS_ADDR);

    assign desc_sel = desc_off[2 +: $bits(endpoint_pkg::msg_id_t)];
    assign tx_idx   = tx_off[2 +: $bits(endpoint_pkg::word_idx_t)];
    assign rx_idx   = rx_off[2 +: $bits(endpoint_pkg::word_idx_t)];
    assign send_msg = wdata[$bits(endpoint_pkg::msg_id_t)-1:0];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `ENDPOINT_NUM_MSGS; i++) begin
                desc_start[i] <= '0;
                desc_len[i]   <= '0;
            end
        end else if (desc_wen) begin
            desc_start[desc_sel] <=
                wdata[`ENDPOINT_DESC_START_LSB +: $bits(endpoint_pkg::word_idx_t)];
            desc_len[desc_sel] <= wdata[`ENDPOINT_DESC_LEN_LSB +: $bits(endpoint_pkg::pkt_len_t)];
        end
    end

    always_comb begin
        desc_word = '0;   // Unused descriptor bits read as zero
        desc_word[`ENDPOINT_DESC_START_LSB +: $bits(endpoint_pkg::word_idx_t)] = desc_start[desc_sel];
        desc_word[`ENDPOINT_DESC_LEN_LSB +: $bits(endpoint_pkg::pkt_len_t)]    = desc_len[desc_sel];
    end

    always_comb begin
        rdata          = '0;
        error          = 1'b0;
        request_stall  = 1'b0;
        desc_wen       = 1'b0;
        send           = 1'b0;
        tx_bus_wen     = 1'b0;
        fifo_pop       = 1'b0;
        clear_overflow = 1'b0;
        if (ren || wen) begin
            if (desc_hit) begin
                if (wen) desc_wen = 1'b1;
                else rdata = desc_word;
            end else if (send_hit) begin
                if (wen && (wdata >= endpoint_pkg::word_t'(`ENDPOINT_NUM_MSGS) || tx_busy)) begin
                    error = 1'b1;
                end else if (wen) begin
                    send = 1'b1;
                end
            end else if (tx_hit) begin
                if (tx_owned) request_stall = 1'b1;   // Payload streaming holds the read port
                else if (wen) tx_bus_wen = 1'b1;
                else rdata = tx_cache_rdata;
            end else if (rx_hit) begin
                if (wen) error = 1'b1;
                else rdata = rx_cache_rdata;
            end else if (pop_hit) begin
                if (wen) begin
                    error = 1'b1;
                end else if (fifo_count != '0) begin
                    rdata    = {1'b1, 12'b0, fifo_head};
                    fifo_pop = 1'b1;
                end
            end else if (status_hit) begin
                if (wen) begin
                    error = 1'b1;
                end else begin
                    rdata          = {23'b0, overflow, 4'b0, fifo_count};
                    clear_overflow = 1'b1;
                end
            end else begin
                error = 1'b1;
            end
        end
    end

    assign tx_cache_raddr = tx_owned ? tx_fsm_raddr : tx_idx;

    word_cache tx_cache (
        .clk(clk),
        .n_rst(n_rst),
        .wen(tx_bus_wen),
        .waddr(tx_idx),
        .wdata(wdata),
        .raddr(tx_cache_raddr),
        .rdata(tx_cache_rdata)
    );

    word_cache rx_cache (
        .clk(clk),
        .n_rst(n_rst),
        .wen(rx_wen),
        .waddr(rx_waddr),
        .wdata(rx_wdata),
        .raddr(rx_idx),
        .rdata(rx_cache_rdata)
    );

    tx_fsm tx (
        .clk(clk),
        .n_rst(n_rst),
        .send(send),
        .send_msg(send_msg),
        .start_word(desc_start[send_msg]),
        .send_len(desc_len[send_msg]),
        .node_id(node_id),
        .cache_raddr(tx_fsm_raddr),
        .cache_rdata(tx_cache_rdata),
        .cache_owned(tx_owned),
        .out_valid(out_valid),
        .out_data(out_data),
        .tx_busy(tx_busy)
    );

    rx_fsm rx (
        .clk(clk),
        .n_rst(n_rst),
        .node_id(node_id),
        .in_valid(in_valid),
        .in_data(in_data),
        .cache_wen(rx_wen),
        .cache_waddr(rx_waddr),
        .cache_wdata(rx_wdata),
        .post(post),
        .entry(post_entry)
    );

    req_fifo #(.DEPTH(`ENDPOINT_FIFO_DEPTH)) requestor_fifo (
        .clk(clk),
        .n_rst(n_rst),
        .push(post),
        .push_entry(post_entry),
        .pop(fifo_pop),
        .head(fifo_head),
        .count(fifo_count),
        .overflow(overflow),
        .clear_overflow(clear_overflow)
    );

endmodule

// ==== test/endpoint_model.svh ====
`ifndef ENDPOINT_MODEL_SVH
`define ENDPOINT_MODEL_SVH

endpoint_pkg::word_t      tx_image [`ENDPOINT_CACHE_WORDS];
endpoint_pkg::word_t      rx_image [`ENDPOINT_CACHE_WORDS];
endpoint_pkg::word_idx_t  desc_start_ref [`ENDPOINT_NUM_MSGS];
endpoint_pkg::pkt_len_t   desc_len_ref [`ENDPOINT_NUM_MSGS];
int                       rx_ptr_ref;      // Receive write pointer
endpoint_pkg::req_entry_t entry_queue [$];
logic                     overflow_ref;

function automatic void reset_model();
    for (int i = 0; i < `ENDPOINT_CACHE_WORDS; i++) begin
        tx_image[i] = '0;
        rx_image[i] = '0;
    end
    for (int m = 0; m < `ENDPOINT_NUM_MSGS; m++) begin
        desc_start_ref[m] = '0;
        desc_len_ref[m]   = '0;
    end
    rx_ptr_ref   = 0;
    overflow_ref = 1'b0;
    entry_queue.delete();
endfunction

// Header of a send, destination is message plus one
function automatic endpoint_pkg::word_t header_for(input int m, input endpoint_pkg::node_id_t src);
    endpoint_pkg::word_t h;
    h = '0;
    h[`ENDPOINT_HDR_DEST_LSB +: 4] = 4'((m + 1) % 16);
    h[`ENDPOINT_HDR_SRC_LSB +: 4]  = src;
    h[`ENDPOINT_HDR_MSG_LSB +: 2]  = 2'(m);
    h[`ENDPOINT_HDR_LEN_LSB +: 4]  = desc_len_ref[m];
    return h;
endfunction

function automatic endpoint_pkg::word_t desc_readback(input int m);
    endpoint_pkg::word_t d;
    d = '0;
    d[`ENDPOINT_DESC_START_LSB +: 7] = desc_start_ref[m];
    d[`ENDPOINT_DESC_LEN_LSB +: 4]   = desc_len_ref[m];
    return d;
endfunction

// Start word field is 9 bits wide, top two bits stay zero
function automatic endpoint_pkg::req_entry_t pack_entry(input logic [3:0] src, input logic [1:0] msg,
                                                        input logic [6:0] start, input logic [3:0] len);
    return {src, msg, 2'b00, start, len};
endfunction

function automatic void store_rx_word(input endpoint_pkg::word_t w);
    rx_image[rx_ptr_ref] = w;
    rx_ptr_ref = (rx_ptr_ref + 1) % `ENDPOINT_CACHE_WORDS;
endfunction

function automatic void post_entry(input endpoint_pkg::req_entry_t e);
    if (entry_queue.size() < `ENDPOINT_FIFO_DEPTH) entry_queue.push_back(e);
    else overflow_ref = 1'b1;   // Full FIFO loses the entry
endfunction

`endif

// ==== test/endpoint_tb.sv ====
`timescale 1ns/100ps

`include "endpoint_settings.svh"

module endpoint_tb;

    localparam int CLK_PERIOD = 4;
    localparam endpoint_pkg::node_id_t NODE = 4'h5;
    localparam int RX_PACKETS = 12;
    localparam int OVF_PACKETS = 6;
    // Rough cycle cost of each test, summed for the watchdog
    localparam int TEST_CYCLES = 4 * (`ENDPOINT_CACHE_WORDS + `ENDPOINT_NUM_MSGS)
                               + 24 * `ENDPOINT_NUM_MSGS
                               + 100
                               + RX_PACKETS * 74 + 4 * `ENDPOINT_CACHE_WORDS
                               + OVF_PACKETS * 24 + 40
                               + 120;
    localparam int MARGIN_CYCLES = 200;

    logic clk, n_rst, ren, wen, in_valid;
    logic error, request_stall, out_valid, tx_busy;
    endpoint_pkg::node_id_t  node_id;
    endpoint_pkg::bus_addr_t addr;
    endpoint_pkg::word_t     wdata, rdata, in_data, out_data;

    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int done_cycle;       // Cycle in which the last bus request completed
    int stall_cycles;
    endpoint_pkg::word_t out_words [$];
    int                  out_cycles [$];

    `include "endpoint_model.svh"

    endpoint UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin
        if (out_valid) begin   // Collect everything sent to the switch
            out_words.push_back(out_data);
            out_cycles.push_back(cycle);
        end
    end

    task automatic check_word(input string name, input endpoint_pkg::word_t got,
                              input endpoint_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_entry(input string name, input endpoint_pkg::req_entry_t got,
                               input endpoint_pkg::req_entry_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    function automatic endpoint_pkg::bus_addr_t tx_addr(input int i);
        return `ENDPOINT_TX_CACHE_BASE + 16'(4 * i);
    endfunction

    function automatic endpoint_pkg::bus_addr_t rx_addr(input int i);
        return `ENDPOINT_RX_CACHE_BASE + 16'(4 * i);
    endfunction

    function automatic endpoint_pkg::bus_addr_t desc_addr(input int m);
        return `ENDPOINT_DESC_BASE + 16'(4 * m);
    endfunction

    task automatic issue_request(input logic is_write, input endpoint_pkg::bus_addr_t a,
                                 input endpoint_pkg::word_t d, output endpoint_pkg::word_t rd,
                                 output logic err);
        @(posedge clk);
        ren   <= !is_write;
        wen   <= is_write;
        addr  <= a;
        wdata <= d;
        stall_cycles = 0;
        @(negedge clk);
        while (request_stall && stall_cycles < 40) begin   // Hold the request unchanged
            stall_cycles++;
            @(negedge clk);
        end
        if (request_stall) report_failure("Bus request still stalled after 40 cycles");
        rd = rdata;
        err = error;
        done_cycle = cycle;
        @(posedge clk);
        ren <= 1'b0;
        wen <= 1'b0;
    endtask

    task automatic write_word(input endpoint_pkg::bus_addr_t a, input endpoint_pkg::word_t d,
                              input logic exp_err);
        endpoint_pkg::word_t rd;
        logic err;
        issue_request(1'b1, a, d, rd, err);
        check_flag("error", err, exp_err);
    endtask

    task automatic read_word(input endpoint_pkg::bus_addr_t a, input logic exp_err,
                             output endpoint_pkg::word_t rd);
        logic err;
        issue_request(1'b0, a, '0, rd, err);
        check_flag("error", err, exp_err);
    endtask

    task automatic expect_read(input endpoint_pkg::bus_addr_t a, input endpoint_pkg::word_t exp);
        endpoint_pkg::word_t rd;
        read_word(a, 1'b0, rd);
        check_word($sformatf("rdata @%h", a), rd, exp);
    endtask

    task automatic program_desc(input int m, input endpoint_pkg::word_t d);
        write_word(desc_addr(m), d, 1'b0);
        desc_start_ref[m] = d[`ENDPOINT_DESC_START_LSB +: 7];
        desc_len_ref[m]   = d[`ENDPOINT_DESC_LEN_LSB +: 4];
    endtask

    task automatic wait_tx_idle();
        int n = 0;
        @(negedge clk);
        while (tx_busy && n < 40) begin
            n++;
            @(negedge clk);
        end
        if (tx_busy) report_failure("tx_busy stayed high after a send");
    endtask

    // Header one cycle after the send, then the payload back to back
    task automatic check_packet(input int m, input int sent);
        int idx;
        if (out_words.size() != int'(desc_len_ref[m]) + 1) begin
            report_failure($sformatf("Send of message %0d gave %0d switch words, expected %0d",
                                     m, out_words.size(), desc_len_ref[m] + 1));
        end else begin
            check_word("out_data header", out_words[0], header_for(m, NODE));
            for (int i = 0; i <= int'(desc_len_ref[m]); i++) begin
                if (out_cycles[i] != sent + 1 + i) begin
                    report_failure($sformatf("Switch word %0d of message %0d out of step", i, m));
                end
                if (i > 0) begin
                    idx = (int'(desc_start_ref[m]) + i - 1) % `ENDPOINT_CACHE_WORDS;
                    check_word("out_data payload", out_words[i], tx_image[idx]);
                end
            end
        end
        out_words.delete();
        out_cycles.delete();
    endtask

    task automatic drive_word(input endpoint_pkg::word_t w);
        repeat ($urandom_range(0, 3)) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= w;
    endtask

    task automatic send_packet(input logic mine, input endpoint_pkg::pkt_len_t len);
        endpoint_pkg::word_t hdr, w;
        logic [6:0] start;
        hdr = $urandom;
        hdr[`ENDPOINT_HDR_DEST_LSB +: 4] = mine ? NODE : NODE + 4'($urandom_range(1, 15));
        hdr[`ENDPOINT_HDR_LEN_LSB +: 4]  = len;
        start = 7'(rx_ptr_ref);
        drive_word(hdr);
        for (int i = 0; i < int'(len); i++) begin
            w = $urandom;
            drive_word(w);
            if (mine) store_rx_word(w);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);   // Let the entry reach the FIFO
        if (mine) begin
            post_entry(pack_entry(hdr[`ENDPOINT_HDR_SRC_LSB +: 4], hdr[`ENDPOINT_HDR_MSG_LSB +: 2],
                                  start, len));
        end
    endtask

    task automatic pop_and_compare();
        endpoint_pkg::word_t rd;
        endpoint_pkg::req_entry_t exp;
        read_word(`ENDPOINT_FIFO_POP_ADDR, 1'b0, rd);
        if (entry_queue.size() == 0) begin
            check_word("rdata empty pop", rd, '0);
        end else begin
            exp = entry_queue.pop_front();
            check_flag("pop valid bit", rd[31], 1'b1);
            check_entry("pop entry", rd[18:0], exp);
        end
    endtask

    task automatic check_status();
        endpoint_pkg::word_t rd, exp;
        exp = '0;
        exp[8] = overflow_ref;
        exp[3:0] = 4'(entry_queue.size());
        read_word(`ENDPOINT_STATUS_ADDR, 1'b0, rd);
        check_word("rdata status", rd, exp);
        overflow_ref = 1'b0;   // Read clears the sticky flag
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Run timed out after %0d cycles with %0d errors", cycle, errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        endpoint_pkg::word_t rd;
        endpoint_pkg::bus_addr_t bad_addr [7];
        int k;
        int sent;
        void'($urandom(27));
        reset_model();
        clk      = 1'b0;
        n_rst    = 1'b0;
        node_id  = NODE;
        ren      = 1'b0;
        wen      = 1'b0;
        addr     = '0;
        wdata    = '0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;

        // Transmit cache and descriptors
        for (int i = 0; i < `ENDPOINT_CACHE_WORDS; i++) begin
            tx_image[i] = $urandom;
            write_word(tx_addr(i), tx_image[i], 1'b0);
        end
        for (int m = 0; m < `ENDPOINT_NUM_MSGS; m++) program_desc(m, $urandom);
        for (int i = 0; i < `ENDPOINT_CACHE_WORDS; i++) expect_read(tx_addr(i), tx_image[i]);
        for (int m = 0; m < `ENDPOINT_NUM_MSGS; m++) expect_read(desc_addr(m), desc_readback(m));

        for (int m = 0; m < `ENDPOINT_NUM_MSGS; m++) begin
            write_word(`ENDPOINT_TX_SEND_ADDR, 32'(m), 1'b0);
            sent = done_cycle;
            wait_tx_idle();
            check_packet(m, sent);
        end

        // Stalled cache read, busy send and out of range send
        program_desc(0, 32'h0000_0800 | 32'($urandom_range(0, 127)));
        write_word(`ENDPOINT_TX_SEND_ADDR, 32'd0, 1'b0);
        sent = done_cycle;
        k = $urandom_range(0, 127);
        read_word(tx_addr(k), 1'b0, rd);
        if (stall_cycles == 0) report_failure("Transmit cache read during a send was not stalled");
        check_word("rdata stalled read", rd, tx_image[k]);
        wait_tx_idle();
        check_packet(0, sent);
        write_word(`ENDPOINT_TX_SEND_ADDR, 32'd0, 1'b0);
        sent = done_cycle;
        write_word(`ENDPOINT_TX_SEND_ADDR, 32'd1, 1'b1);
        wait_tx_idle();
        check_packet(0, sent);
        write_word(`ENDPOINT_TX_SEND_ADDR, 32'(`ENDPOINT_NUM_MSGS + $urandom_range(0, 255)), 1'b1);
        repeat (4) @(negedge clk);
        if (out_words.size() != 0 || tx_busy) report_failure("Refused send still reached the switch");

        // Receive with random gaps and destinations
        for (int p = 0; p < RX_PACKETS; p++) begin
            send_packet($urandom_range(0, 2) != 0, 4'($urandom_range(0, 15)));
            if (entry_queue.size() >= 3) repeat (entry_queue.size()) pop_and_compare();
        end
        repeat (entry_queue.size() + 1) pop_and_compare();
        check_status();
        for (int i = 0; i < `ENDPOINT_CACHE_WORDS; i++) expect_read(rx_addr(i), rx_image[i]);

        // Overflow
        for (int p = 0; p < OVF_PACKETS; p++) send_packet(1'b1, 4'($urandom_range(0, 3)));
        check_status();
        repeat (`ENDPOINT_FIFO_DEPTH + 1) pop_and_compare();
        check_status();

        // Address errors leave everything untouched
        send_packet(1'b1, 4'd2);
        bad_addr = '{16'h0010, 16'h1000, 16'h1008, 16'h2200, 16'h3200, 16'h3408, 16'hfffc};
        foreach (bad_addr[i]) begin
            write_word(bad_addr[i], $urandom, 1'b1);
            read_word(bad_addr[i], 1'b1, rd);
        end
        k = $urandom_range(0, 127);
        write_word(rx_addr(k), $urandom, 1'b1);
        write_word(`ENDPOINT_FIFO_POP_ADDR, $urandom, 1'b1);
        write_word(`ENDPOINT_STATUS_ADDR, $urandom, 1'b1);
        expect_read(rx_addr(k), rx_image[k]);
        expect_read(tx_addr(k), tx_image[k]);
        for (int m = 0; m < `ENDPOINT_NUM_MSGS; m++) expect_read(desc_addr(m), desc_readback(m));
        check_status();
        pop_and_compare();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
+incdir+test
hw/endpoint_pkg.sv
hw/word_cache.sv
hw/word_counter.sv
hw/tx_fsm.sv
hw/rx_fsm.sv
hw/req_fifo.sv
hw/endpoint.sv
test/endpoint_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = endpoint_tb
FILELIST = vlog.f
PASS_MSG = All checks passed

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
